//--- include/fetch_consts.svh
`ifndef FETCH_CONSTS_SVH
`define FETCH_CONSTS_SVH

// boot ROM entry, first fetch after reset
`define FETCH_BOOT_PC 32'hbfc0_0000

// one instruction pair per fetch step
`define FETCH_PAIR_BYTES 8

// pairs buffered between the bus and the consumer
`define FETCH_QUEUE_DEPTH 4

// bus requests accepted but not yet answered
`define FETCH_MAX_INFLIGHT 2

// consumer side buffer, in pairs
// loaded into the credit counter at reset
`define FETCH_CREDITS 4

`endif

//--- source/fetch_pkg.sv
`default_nettype none

package fetch_pkg;

    typedef logic [31:0] addr_t;
    typedef logic [31:0] instr_t;

    // lower word at the request address, upper word at address+4
    typedef logic [63:0] line_t;

    typedef struct packed {
        logic  valid;
        addr_t addr;
    } ibus_req_t;

    typedef struct packed {
        logic  addr_ok;
        logic  data_ok;
        line_t data;
    } ibus_resp_t;

    // one-cycle pulse standing in for branch, exception and eret
    typedef struct packed {
        logic  valid;
        addr_t target;
    } redirect_t;

    typedef struct packed {
        addr_t  pc;
        instr_t instr;
    } fetch_slot_t;

    // slot[0] holds pc, slot[1] holds pc+4
    typedef struct packed {
        logic              valid;
        logic              exc;
        fetch_slot_t [1:0] slot;
    } fetch_pair_t;

    // what the bus side writes into the queue
    typedef struct packed {
        logic              exc;
        fetch_slot_t [1:0] slot;
    } queue_entry_t;

endpackage

`default_nettype wire

//--- source/pc_gen.sv
`timescale 1ns/10ps
`default_nettype none

`include "fetch_consts.svh"

module pc_gen (
    input  wire                       clk,
    input  wire                       reset,
    input  wire fetch_pkg::redirect_t redirect,
    input  wire                       advance,
    input  wire                       halt,
    output fetch_pkg::addr_t          fetch_pc
);
    import fetch_pkg::*;

    addr_t pc;
    addr_t pc_next;
    addr_t saved_target;
    logic  saved_valid;
    logic  park;

    // request still waiting for addr_ok, so the address must hold
    assign park = redirect.valid && halt;

    // parked redirect flag
    always_ff @(posedge clk) begin
        if (reset) begin
            saved_valid <= 1'b0;
        end else if (park) begin
            saved_valid <= 1'b1;
        end else if (!halt) begin
            saved_valid <= 1'b0;
        end
    end

    // a later redirect during the same stall overwrites the earlier one
    always_ff @(posedge clk) begin
        if (park) begin
            saved_target <= redirect.target;
        end
    end

    // priority: live redirect, then parked redirect, then sequential
    always_comb begin
        pc_next = pc;
        if (!halt) begin
            if (redirect.valid) begin
                pc_next = redirect.target;
            end else if (saved_valid) begin
                pc_next = saved_target;
            end else if (advance) begin
                pc_next = pc + addr_t'(`FETCH_PAIR_BYTES);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= `FETCH_BOOT_PC;
        end else begin
            pc <= pc_next;
        end
    end

    assign fetch_pc = pc;

endmodule

`default_nettype wire

//--- source/ibus_master.sv
`timescale 1ns/10ps
`default_nettype none

`include "fetch_consts.svh"

module ibus_master (
    input  wire                         clk,
    input  wire                         reset,
    input  wire fetch_pkg::addr_t       fetch_pc,
    input  wire                         redirect_valid,
    output fetch_pkg::ibus_req_t        ireq,
    input  wire fetch_pkg::ibus_resp_t  iresp,
    input  wire [2:0]                   free_slots,
    output logic                        advance,
    output logic                        halt,
    output logic                        push,
    output fetch_pkg::queue_entry_t     push_entry
);
    import fetch_pkg::*;

    logic [1:0] inflight;
    logic [1:0] inflight_next;
    logic [1:0] stale;
    logic       req_pending;
    logic       pend_stale;
    logic       stopped;
    logic       misaligned;
    logic       fits;
    logic       accept;
    logic       live;
    logic       exc_push;
    addr_t      pc_fifo [`FETCH_MAX_INFLIGHT];
    logic       wr_ptr;
    logic       rd_ptr;
    addr_t      resp_pc;

    assign misaligned = fetch_pc[1:0] != 2'b00;

    // queue must have room for every answer still on its way
    assign fits = ({1'b0, inflight} < free_slots) &&
                  (inflight < 2'(`FETCH_MAX_INFLIGHT));

    // once raised, valid stays up until addr_ok
    assign ireq.valid = !reset &&
                        (req_pending ||
                         (!stopped && !misaligned && fits && !redirect_valid));
    assign ireq.addr  = fetch_pc;

    assign accept = ireq.valid && iresp.addr_ok;
    assign halt   = ireq.valid && !iresp.addr_ok;
    assign live   = iresp.data_ok && (stale == 2'd0);

    // bad pc only after older answers have drained
    assign exc_push = misaligned && !stopped && (inflight == 2'd0) &&
                      (free_slots != 3'd0) && !redirect_valid;

    assign advance = accept || exc_push;
    assign push    = live || exc_push;

    always_comb begin
        inflight_next = inflight;
        if (accept && !iresp.data_ok) begin
            inflight_next = inflight + 2'd1;
        end else if (!accept && iresp.data_ok) begin
            inflight_next = inflight - 2'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            inflight    <= 2'd0;
            req_pending <= 1'b0;
        end else begin
            inflight    <= inflight_next;
            req_pending <= halt;
        end
    end

    // everything outstanding at a redirect belongs to the old stream
    always_ff @(posedge clk) begin
        if (reset) begin
            stale <= 2'd0;
        end else if (redirect_valid) begin
            stale <= inflight_next;
        end else if (accept && pend_stale && !(iresp.data_ok && stale != 2'd0)) begin
            stale <= stale + 2'd1;
        end else if (!(accept && pend_stale) && iresp.data_ok && stale != 2'd0) begin
            stale <= stale - 2'd1;
        end
    end

    // waiting request was overtaken by a redirect
    always_ff @(posedge clk) begin
        if (reset) begin
            pend_stale <= 1'b0;
        end else if (redirect_valid && halt) begin
            pend_stale <= 1'b1;
        end else if (accept) begin
            pend_stale <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            stopped <= 1'b0;
        end else if (redirect_valid) begin
            stopped <= 1'b0;
        end else if (exc_push) begin
            stopped <= 1'b1;
        end
    end

    // addresses of accepted requests, in bus order
    always_ff @(posedge clk) begin
        if (accept) begin
            pc_fifo[wr_ptr] <= fetch_pc;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= 1'b0;
            rd_ptr <= 1'b0;
        end else begin
            if (accept) begin
                wr_ptr <= !wr_ptr;
            end
            if (iresp.data_ok) begin
                rd_ptr <= !rd_ptr;
            end
        end
    end

    assign resp_pc = pc_fifo[rd_ptr];

    always_comb begin
        push_entry = '0;
        if (exc_push) begin
            push_entry.exc         = 1'b1;
            push_entry.slot[0].pc  = fetch_pc;
            push_entry.slot[1].pc  = fetch_pc + 32'd4;
        end else begin
            push_entry.slot[0].pc    = resp_pc;
            push_entry.slot[0].instr = iresp.data[31:0];
            push_entry.slot[1].pc    = resp_pc + 32'd4;
            push_entry.slot[1].instr = iresp.data[63:32];
        end
    end

endmodule

`default_nettype wire

//--- source/fetch_queue.sv
`timescale 1ns/10ps
`default_nettype none

`include "fetch_consts.svh"

module fetch_queue (
    input  wire                          clk,
    input  wire                          reset,
    input  wire                          push,
    input  wire fetch_pkg::queue_entry_t push_entry,
    input  wire                          flush,
    input  wire                          credit_return,
    output logic [2:0]                   free_slots,
    output fetch_pkg::fetch_pair_t       fetch_out
);
    import fetch_pkg::*;

    queue_entry_t mem [`FETCH_QUEUE_DEPTH];
    queue_entry_t head;
    logic [1:0]   rd_ptr;
    logic [1:0]   wr_ptr;
    logic [2:0]   count;
    logic [2:0]   credits;
    logic         pop;
    logic         wr_en;

    // old-stream entries are never written or shown once a redirect hits
    assign wr_en = push && !flush;
    assign pop   = (count != 3'd0) && (credits != 3'd0) && !flush;

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= push_entry;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            rd_ptr <= 2'd0;
            wr_ptr <= 2'd0;
        end else if (flush) begin
            rd_ptr <= 2'd0;
            wr_ptr <= 2'd0;
        end else begin
            if (wr_en) begin
                wr_ptr <= wr_ptr + 2'd1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 2'd1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            count <= 3'd0;
        end else if (flush) begin
            count <= 3'd0;
        end else begin
            case ({wr_en, pop})
                2'b10: count <= count + 3'd1;
                2'b01: count <= count - 3'd1;
                default: count <= count;
            endcase
        end
    end

    // credits mirror free space in the consumer buffer
    always_ff @(posedge clk) begin
        if (reset) begin
            credits <= 3'(`FETCH_CREDITS);
        end else begin
            case ({pop, credit_return})
                2'b10: credits <= credits - 3'd1;
                2'b01: credits <= credits + 3'd1;
                default: credits <= credits;
            endcase
        end
    end

    assign free_slots = 3'(`FETCH_QUEUE_DEPTH) - count;

    assign head = mem[rd_ptr];

    // one pulse per pair handed over
    always_comb begin
        fetch_out.valid = pop;
        fetch_out.exc   = head.exc;
        fetch_out.slot  = head.slot;
    end

endmodule

`default_nettype wire

//--- source/fetch_unit.sv
`timescale 1ns/10ps
`default_nettype none

module fetch_unit (
    input  wire                         clk,
    input  wire                         reset,
    output fetch_pkg::ibus_req_t        ireq,
    input  wire fetch_pkg::ibus_resp_t  iresp,
    input  wire fetch_pkg::redirect_t   redirect,
    output fetch_pkg::fetch_pair_t      fetch_out,
    input  wire                         credit_return
);
    import fetch_pkg::*;

    addr_t        fetch_pc;
    logic         advance;
    logic         halt;
    logic         push;
    queue_entry_t push_entry;
    logic [2:0]   free_slots;

    pc_gen pc_gen_inst (
        .clk      (clk),
        .reset    (reset),
        .redirect (redirect),
        .advance  (advance),
        .halt     (halt),
        .fetch_pc (fetch_pc)
    );

    ibus_master ibus_master_inst (
        .clk            (clk),
        .reset          (reset),
        .fetch_pc       (fetch_pc),
        .redirect_valid (redirect.valid),
        .ireq           (ireq),
        .iresp          (iresp),
        .free_slots     (free_slots),
        .advance        (advance),
        .halt           (halt),
        .push           (push),
        .push_entry     (push_entry)
    );

    // a redirect also empties the queue
    fetch_queue fetch_queue_inst (
        .clk           (clk),
        .reset         (reset),
        .push          (push),
        .push_entry    (push_entry),
        .flush         (redirect.valid),
        .credit_return (credit_return),
        .free_slots    (free_slots),
        .fetch_out     (fetch_out)
    );

endmodule

`default_nettype wire

//--- sim/fetch_unit_props.sv
`timescale 1ns/10ps
`default_nettype none

`include "fetch_consts.svh"

module fetch_unit_props (
    input wire                         clk,
    input wire                         reset,
    input wire fetch_pkg::ibus_req_t   ireq,
    input wire fetch_pkg::ibus_resp_t  iresp,
    input wire fetch_pkg::fetch_pair_t fetch_out,
    input wire                         credit_return,
    input wire                         push,
    input wire [1:0]                   stale
);
    import fetch_pkg::*;

    int         fail_count = 0;
    logic [2:0] credits;

    // credits as the consumer sees them
    always_ff @(posedge clk) begin
        if (reset) begin
            credits <= 3'(`FETCH_CREDITS);
        end else begin
            credits <= credits - 3'(fetch_out.valid) + 3'(credit_return);
        end
    end

    addr_held: assert property (
        @(posedge clk) disable iff (reset)
        !reset && ireq.valid && !iresp.addr_ok |=> ireq.valid && $stable(ireq.addr)
    ) else begin
        $error("request address changed or valid dropped before addr_ok");
        fail_count++;
    end

    stale_dropped: assert property (
        @(posedge clk) disable iff (reset)
        stale != 2'd0 |-> !push
    ) else begin
        $error("queue push while stale responses were pending");
        fail_count++;
    end

    credit_guard: assert property (
        @(posedge clk) disable iff (reset)
        fetch_out.valid |-> (credits != 3'd0)
    ) else begin
        $error("fetch_out.valid with no credit left");
        fail_count++;
    end

endmodule

bind fetch_unit fetch_unit_props i_props (
    .clk           (clk),
    .reset         (reset),
    .ireq          (ireq),
    .iresp         (iresp),
    .fetch_out     (fetch_out),
    .credit_return (credit_return),
    .push          (push),
    .stale         (ibus_master_inst.stale)
);

`default_nettype wire

//--- sim/tb_fetch_unit.sv
`timescale 1ns/10ps
`default_nettype none

`include "fetch_consts.svh"

module tb_fetch_unit;
    import fetch_pkg::*;

    localparam int NUM_REDIRECTS   = 40;
    localparam int WATCHDOG_CYCLES = NUM_REDIRECTS * 200 + 2000;

    logic        clk;
    logic        reset;
    ibus_req_t   ireq;
    ibus_resp_t  iresp;
    redirect_t   redirect;
    fetch_pair_t fetch_out;
    logic        credit_return;

    // separate streams for the redirect sequence and for the bus and consumer models
    logic [31:0] seq_rng = 32'h24ec6e04;
    logic [31:0] env_rng = ~32'h24ec6e04;
    int          cycle;
    addr_t       bus_addr_q[$];
    int          bus_due_q[$];
    int          credit_due_q[$];
    int          hold_left;

    // reference model state
    addr_t       exp_pc;
    logic        exp_stopped;
    int          pairs_seen;
    int          credits_back;

    fetch_unit i_dut (
        .clk           (clk),
        .reset         (reset),
        .ireq          (ireq),
        .iresp         (iresp),
        .redirect      (redirect),
        .fetch_out     (fetch_out),
        .credit_return (credit_return)
    );

    function automatic int unsigned rand_below(ref logic [31:0] state, input int unsigned n);
        state = state * 32'd1664525 + 32'd1013904223;
        return (state >> 8) % n;
    endfunction

    task automatic abort_run(string reason);
        $display("%s", reason);
        $display("** FAIL **");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_word(string name, logic [31:0] got, logic [31:0] expected);
        assert (got === expected) else
            abort_run($sformatf("mismatch at %0t: %s is %h, expected %h",
                                $time, name, got, expected));
    endtask

    // memory holds ~addr at every word address
    task automatic check_pair();
        logic misaligned;
        misaligned = exp_pc[1:0] != 2'b00;
        assert (!exp_stopped) else
            abort_run("a pair was delivered after an exception pair, before any redirect");
        check_word("fetch_out.exc", 32'(fetch_out.exc), 32'(misaligned));
        check_word("fetch_out.slot[0].pc", fetch_out.slot[0].pc, exp_pc);
        check_word("fetch_out.slot[0].instr", fetch_out.slot[0].instr,
                   misaligned ? 32'd0 : ~exp_pc);
        check_word("fetch_out.slot[1].pc", fetch_out.slot[1].pc, exp_pc + 32'd4);
        check_word("fetch_out.slot[1].instr", fetch_out.slot[1].instr,
                   misaligned ? 32'd0 : ~(exp_pc + 32'd4));
        if (misaligned) begin
            exp_stopped = 1'b1;
        end else begin
            exp_pc = exp_pc + `FETCH_PAIR_BYTES;
        end
        pairs_seen++;
    endtask

    task automatic wait_for_pairs(int n);
        int goal;
        goal = pairs_seen + n;
        while (pairs_seen < goal && !exp_stopped) begin
            @(negedge clk);
        end
    endtask

    // aligned targets with an occasional low 2'b10
    task automatic pulse_redirect();
        addr_t target;
        target = 32'h8000_0000 | (addr_t'(rand_below(seq_rng, 32'h1_0000)) << 3);
        if (rand_below(seq_rng, 6) == 0) begin
            target[1:0] = 2'b10;
        end
        redirect.valid  = 1'b1;
        redirect.target = target;
        @(negedge clk);
        redirect.valid = 1'b0;
    endtask

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // bus and consumer observed at the rising edge
    always @(posedge clk) begin
        if (!reset) begin
            cycle++;
            assert (i_dut.i_props.fail_count == 0) else
                abort_run("a bus or credit property failed");
            if (ireq.valid) begin
                assert (ireq.addr[1:0] == 2'b00) else
                    abort_run($sformatf("bus request at misaligned address %h", ireq.addr));
                if (iresp.addr_ok) begin
                    bus_addr_q.push_back(ireq.addr);
                    bus_due_q.push_back(cycle + int'(rand_below(env_rng, 4)));
                end
            end
            if (redirect.valid) begin
                assert (!fetch_out.valid) else
                    abort_run("a pair was delivered in the redirect cycle");
                exp_pc      = redirect.target;
                exp_stopped = 1'b0;
            end else if (fetch_out.valid) begin
                assert (pairs_seen - credits_back < `FETCH_CREDITS) else
                    abort_run("a pair was delivered while the consumer buffer was full");
                check_pair();
                credit_due_q.push_back(cycle + 1 + int'(rand_below(env_rng, 6)));
            end
            if (credit_return) begin
                credits_back++;
            end
        end
    end

    // memory and consumer models drive on the falling edge
    always @(negedge clk) begin : drive_models
        addr_t word_addr;
        if (reset) begin
            assert (!ireq.valid && !fetch_out.valid) else
                abort_run("bus request or pair output active during reset");
            iresp         = '0;
            credit_return = 1'b0;
            hold_left     = 0;
        end else begin
            iresp.addr_ok = rand_below(env_rng, 8) < 5;
            iresp.data_ok = 1'b0;
            iresp.data    = {env_rng, ~env_rng};
            if (bus_due_q.size() > 0 && bus_due_q[0] <= cycle) begin
                word_addr = bus_addr_q.pop_front();
                void'(bus_due_q.pop_front());
                iresp.data_ok = 1'b1;
                iresp.data    = {~(word_addr + 32'd4), ~word_addr};
            end
            // consumer sometimes sits on its credits for a while
            if (hold_left > 0) begin
                hold_left--;
            end else if (rand_below(env_rng, 150) == 0) begin
                hold_left = 20 + int'(rand_below(env_rng, 40));
            end
            credit_return = 1'b0;
            if (hold_left == 0 && credit_due_q.size() > 0 && credit_due_q[0] <= cycle) begin
                void'(credit_due_q.pop_front());
                credit_return = 1'b1;
            end
        end
    end

    initial begin : watchdog
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        abort_run($sformatf("timeout: run did not finish within %0d cycles", WATCHDOG_CYCLES));
    end

    initial begin : main_sequence
        int idle;
        reset         = 1'b1;
        redirect      = '0;
        iresp         = '0;
        credit_return = 1'b0;
        cycle         = 0;
        hold_left     = 0;
        pairs_seen    = 0;
        credits_back  = 0;
        exp_pc        = `FETCH_BOOT_PC;
        exp_stopped   = 1'b0;
        repeat (4) @(negedge clk);
        reset <= 1'b0;

        for (int r = 0; r < NUM_REDIRECTS; r++) begin
            wait_for_pairs(rand_below(seq_rng, 8));
            idle = rand_below(seq_rng, 6);
            // give a stopped stream time to show any extra pair
            if (exp_stopped) begin
                idle = idle + 12;
            end
            repeat (idle) @(negedge clk);
            pulse_redirect();
        end
        wait_for_pairs(8);
        repeat (20) @(negedge clk);

        if (i_dut.i_props.fail_count == 0) begin
            $display("** PASS **");
            $finish;
        end else begin
            abort_run($sformatf("%0d bus or credit property failures",
                                i_dut.i_props.fail_count));
        end
    end

endmodule

`default_nettype wire

//--- verilog.f
+incdir+include
source/fetch_pkg.sv
source/pc_gen.sv
source/ibus_master.sv
source/fetch_queue.sv
source/fetch_unit.sv
sim/fetch_unit_props.sv
sim/tb_fetch_unit.sv
